/* rtl/modred_settings.svh */
`ifndef MODRED_SETTINGS_SVH
`define MODRED_SETTINGS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------

// Request operand x and working accumulator base width
`define MODRED_DATA_W 64
// Modulus and result width
`define MODRED_MOD_W 32
// Request tag width
`define MODRED_TAG_W 4

// ------------------------------------------------------------
// Lane count and flow control
// ------------------------------------------------------------

// Peer fold lanes, also the host request credits after reset
`define MODRED_NUM_LANES 2
// Response credits held by the engine after reset
`define MODRED_OUT_CREDITS 2

`endif

/* rtl/modred_arith_pkg.sv */
`include "modred_settings.svh"

package modred_arith_pkg;

  // ------------------------------------------------------------
  // Accumulator sizing
  // ------------------------------------------------------------

  // Two guard bits above x for sign and fold growth
  localparam int ACC_W = `MODRED_DATA_W + 2;

  // ------------------------------------------------------------
  // Modulus classes and fixed primes
  // ------------------------------------------------------------

  typedef enum logic [2:0] {
    MC_NONE,
    MC_MERSENNE,
    MC_FERMAT,
    MC_KYBER,
    MC_DILITHIUM
  } mod_class_e;

  // Kyber prime 3329 with fold width 12
  localparam logic [`MODRED_MOD_W-1:0] KYBER_Q = `MODRED_MOD_W'd3329;
  localparam logic [5:0] KYBER_K = 6'd12;
  // 2^12 mod q is 2^9 + 2^8 - 1
  localparam int KYBER_SH_HI = 9;
  localparam int KYBER_SH_LO = 8;

  // Dilithium prime 8380417 with fold width 23
  localparam logic [`MODRED_MOD_W-1:0] DILITHIUM_Q = `MODRED_MOD_W'd8380417;
  localparam logic [5:0] DILITHIUM_K = 6'd23;
  // 2^23 mod q is 2^13 - 1
  localparam int DILITHIUM_SH = 13;

  // Lane sequencing
  typedef enum logic [1:0] {IDLE, FOLD, CORRECT, DONE} fold_state_e;

endpackage

/* rtl/modred_link_pkg.sv */
`include "modred_settings.svh"

package modred_link_pkg;

  // ------------------------------------------------------------
  // Request and response transport types
  // ------------------------------------------------------------

  // Lane number for arbitration
  typedef logic [$clog2(`MODRED_NUM_LANES)-1:0] lane_idx_t;

  // One bit per lane for start, done and release
  typedef logic [`MODRED_NUM_LANES-1:0] lane_mask_t;

  // Host request tag, echoed on the response
  typedef logic [`MODRED_TAG_W-1:0] tag_t;

endpackage

/* rtl/modred_classifier.sv */
`timescale 1ns/1ps
`include "modred_settings.svh"

module modred_classifier (
  input  logic [`MODRED_MOD_W-1:0]      m_i,
  input  logic [5:0]                    m_bl_i,
  output modred_arith_pkg::mod_class_e  class_o,
  output logic [5:0]                    k_o
);

  // One extra bit so 2^32 is representable
  localparam int PW = `MODRED_MOD_W + 1;

  logic [PW-1:0] m_ext;
  logic [PW-1:0] pow_bl;
  logic [PW-1:0] pow_bl_half;
  logic          bl_ok;
  logic          is_mersenne;
  logic          is_fermat;

  // Legal bit lengths only
  assign bl_ok = (m_bl_i >= 6'd2) && (m_bl_i <= 6'(`MODRED_MOD_W));

  assign m_ext       = {1'b0, m_i};
  // 2^bl and 2^(bl-1)
  assign pow_bl      = PW'(1) << m_bl_i;
  assign pow_bl_half = pow_bl >> 1;

  // All ones across bl bits
  assign is_mersenne = bl_ok && (m_ext == (pow_bl - PW'(1)));
  // Top and bottom bits only
  assign is_fermat   = bl_ok && (m_ext == (pow_bl_half + PW'(1)));

  // ------------------------------------------------------------
  // Class priority
  // ------------------------------------------------------------
  always_comb begin
    class_o = modred_arith_pkg::MC_NONE;
    k_o     = 6'd0;
    if (bl_ok && (m_i == modred_arith_pkg::KYBER_Q)) begin
      class_o = modred_arith_pkg::MC_KYBER;
      k_o     = modred_arith_pkg::KYBER_K;
    end else if (bl_ok && (m_i == modred_arith_pkg::DILITHIUM_Q)) begin
      class_o = modred_arith_pkg::MC_DILITHIUM;
      k_o     = modred_arith_pkg::DILITHIUM_K;
    end else if (is_mersenne) begin
      // 2^k = 1 mod m
      class_o = modred_arith_pkg::MC_MERSENNE;
      k_o     = m_bl_i;
    end else if (is_fermat) begin
      // 2^k = -1 mod m, k one below the length
      class_o = modred_arith_pkg::MC_FERMAT;
      k_o     = m_bl_i - 6'd1;
    end
  end

endmodule

/* rtl/modred_fold_lane.sv */
`timescale 1ns/1ps
`include "modred_settings.svh"

module modred_fold_lane (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic [`MODRED_DATA_W-1:0]     x_i,
  input  logic [`MODRED_MOD_W-1:0]      m_i,
  input  logic [5:0]                    m_bl_i,
  input  modred_link_pkg::tag_t         tag_i,
  input  logic                          release_i,
  output logic                          done_o,
  output logic [`MODRED_MOD_W-1:0]      result_o,
  output logic                          err_o,
  output modred_link_pkg::tag_t         tag_o
);

  localparam int AW = modred_arith_pkg::ACC_W;

  modred_arith_pkg::fold_state_e state_q;
  modred_arith_pkg::fold_state_e state_d;

  // Classification of the incoming request
  modred_arith_pkg::mod_class_e  class_in;
  logic [5:0]                    k_in;

  // Operands captured at start
  modred_arith_pkg::mod_class_e  class_q;
  logic [5:0]                    k_q;
  logic [`MODRED_MOD_W-1:0]      m_q;
  modred_link_pkg::tag_t         tag_q;
  logic                          err_q;

  // Working value
  logic signed [AW-1:0] acc_q;
  logic signed [AW-1:0] acc_d;

  // Fold and correction terms
  logic signed [AW-1:0] hi;
  logic signed [AW-1:0] lo;
  logic signed [AW-1:0] scaled;
  logic signed [AW-1:0] top;
  logic signed [AW-1:0] m_ext;
  logic                 fits;
  logic                 acc_neg;
  logic                 acc_ge_m;
  logic                 take;

  modred_classifier u_classifier (
    .m_i     (m_i),
    .m_bl_i  (m_bl_i),
    .class_o (class_in),
    .k_o     (k_in)
  );

  assign take = (state_q == modred_arith_pkg::IDLE) && start_i;

  // ------------------------------------------------------------
  // Fold datapath
  // ------------------------------------------------------------

  // v = hi * 2^k + lo with lo in [0, 2^k)
  assign hi = acc_q >>> k_q;
  assign lo = acc_q - (hi <<< k_q);

  // hi times (2^k mod m)
  always_comb begin
    case (class_q)
      modred_arith_pkg::MC_FERMAT: begin
        scaled = -hi;
      end
      modred_arith_pkg::MC_KYBER: begin
        scaled = (hi <<< modred_arith_pkg::KYBER_SH_HI)
               + (hi <<< modred_arith_pkg::KYBER_SH_LO) - hi;
      end
      modred_arith_pkg::MC_DILITHIUM: begin
        scaled = (hi <<< modred_arith_pkg::DILITHIUM_SH) - hi;
      end
      default: begin
        // Mersenne
        scaled = hi;
      end
    endcase
  end

  // Stop folding once the value fits in k+1 bits plus sign
  assign top  = acc_q >>> (k_q + 6'd1);
  assign fits = (top == '0) || (top == '1);

  // ------------------------------------------------------------
  // Correction datapath
  // ------------------------------------------------------------
  assign m_ext    = AW'(m_q);
  assign acc_neg  = acc_q[AW-1];
  assign acc_ge_m = !acc_neg && (acc_q >= m_ext);

  // ------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    acc_d   = acc_q;
    case (state_q)
      modred_arith_pkg::IDLE: begin
        if (start_i) begin
          if (class_in == modred_arith_pkg::MC_NONE) begin
            // Unsupported modulus answers 0 at once
            acc_d   = '0;
            state_d = modred_arith_pkg::DONE;
          end else begin
            acc_d   = AW'(x_i);
            state_d = modred_arith_pkg::FOLD;
          end
        end
      end
      modred_arith_pkg::FOLD: begin
        if (fits) begin
          state_d = modred_arith_pkg::CORRECT;
        end else begin
          acc_d = lo + scaled;
        end
      end
      modred_arith_pkg::CORRECT: begin
        // One add or subtract of m per cycle
        if (acc_neg) begin
          acc_d = acc_q + m_ext;
        end else if (acc_ge_m) begin
          acc_d = acc_q - m_ext;
        end else begin
          state_d = modred_arith_pkg::DONE;
        end
      end
      modred_arith_pkg::DONE: begin
        // Hold until the arbiter takes the result
        if (release_i) begin
          state_d = modred_arith_pkg::IDLE;
        end
      end
      default: begin
        state_d = modred_arith_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= modred_arith_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
    if (take) begin
      class_q <= class_in;
      k_q     <= k_in;
      m_q     <= m_i;
      tag_q   <= tag_i;
      err_q   <= (class_in == modred_arith_pkg::MC_NONE);
    end
  end

  // Result fields
  assign done_o   = (state_q == modred_arith_pkg::DONE);
  assign result_o = acc_q[`MODRED_MOD_W-1:0];
  assign err_o    = err_q;
  assign tag_o    = tag_q;

endmodule

/* rtl/modred_dispatch.sv */
`timescale 1ns/1ps
`include "modred_settings.svh"

module modred_dispatch (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_valid_i,
  input  modred_link_pkg::lane_mask_t lane_release_i,
  output modred_link_pkg::lane_mask_t lane_start_o,
  output logic                        req_credit_o
);

  // Lanes holding a request
  modred_link_pkg::lane_mask_t busy_q;
  modred_link_pkg::lane_mask_t busy_d;
  // Lowest idle lane as a one-hot mask
  modred_link_pkg::lane_mask_t pick;

  // ------------------------------------------------------------
  // Lane selection
  // ------------------------------------------------------------
  always_comb begin
    pick = '0;
    // Downward scan so the lowest idle lane wins
    for (int i = `MODRED_NUM_LANES - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  // Host credits guarantee an idle lane here
  assign lane_start_o = req_valid_i ? pick : '0;

  assign busy_d = (busy_q | lane_start_o) & ~lane_release_i;

  // ------------------------------------------------------------
  // Busy tracking and credit return
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= '0;
      req_credit_o <= 1'b0;
    end else begin
      busy_q       <= busy_d;
      // One credit per released lane
      req_credit_o <= |lane_release_i;
    end
  end

endmodule

/* rtl/modred_result_arb.sv */
`timescale 1ns/1ps
`include "modred_settings.svh"

module modred_result_arb (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  modred_link_pkg::lane_mask_t lane_done_i,
  input  logic [`MODRED_MOD_W-1:0]    lane_result_i [`MODRED_NUM_LANES],
  input  logic                        lane_err_i [`MODRED_NUM_LANES],
  input  modred_link_pkg::tag_t       lane_tag_i [`MODRED_NUM_LANES],
  input  logic                        out_credit_i,
  output modred_link_pkg::lane_mask_t lane_release_o,
  output logic                        resp_valid_o,
  output logic [`MODRED_MOD_W-1:0]    resp_result_o,
  output logic                        resp_err_o,
  output modred_link_pkg::tag_t       resp_tag_o
);

  localparam int CW = $clog2(`MODRED_OUT_CREDITS + 1);

  // Response credits left at the sink
  logic [CW-1:0]               credit_q;
  logic                        have_credit;
  // Last winner for round-robin
  modred_link_pkg::lane_idx_t  last_q;
  modred_link_pkg::lane_idx_t  grant_idx;
  logic                        grant_valid;

  assign have_credit = (credit_q != '0);

  // ------------------------------------------------------------
  // Round-robin search starting after the last winner
  // ------------------------------------------------------------
  always_comb begin
    modred_link_pkg::lane_idx_t cand;
    grant_idx   = last_q;
    grant_valid = 1'b0;
    for (int i = 1; i <= `MODRED_NUM_LANES; i++) begin
      cand = modred_link_pkg::lane_idx_t'((int'(last_q) + i) % `MODRED_NUM_LANES);
      if (!grant_valid && lane_done_i[cand] && have_credit) begin
        grant_idx   = cand;
        grant_valid = 1'b1;
      end
    end
  end

  // Winner goes back to IDLE at the next edge
  assign lane_release_o = grant_valid ?
                          (modred_link_pkg::lane_mask_t'(1) << grant_idx) : '0;

  // ------------------------------------------------------------
  // Pointer, credits and response valid
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q     <= CW'(`MODRED_OUT_CREDITS);
      last_q       <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      // Spend on grant, refill on sink pulse
      credit_q     <= credit_q - CW'(grant_valid) + CW'(out_credit_i);
      resp_valid_o <= grant_valid;
      if (grant_valid) begin
        last_q <= grant_idx;
      end
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (grant_valid) begin
      resp_result_o <= lane_result_i[grant_idx];
      resp_err_o    <= lane_err_i[grant_idx];
      resp_tag_o    <= lane_tag_i[grant_idx];
    end
  end

endmodule

/* rtl/modred_top.sv */
`timescale 1ns/1ps
`include "modred_settings.svh"

module modred_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Request channel
  input  logic                          req_valid_i,
  input  logic [`MODRED_DATA_W-1:0]     req_x_i,
  input  logic [`MODRED_MOD_W-1:0]      req_m_i,
  input  logic [5:0]                    req_m_bl_i,
  input  modred_link_pkg::tag_t         req_tag_i,
  output logic                          req_credit_o,
  // Response channel
  input  logic                          out_credit_i,
  output logic                          resp_valid_o,
  output logic [`MODRED_MOD_W-1:0]      resp_result_o,
  output logic                          resp_err_o,
  output modred_link_pkg::tag_t         resp_tag_o
);

  // Lane handshake masks
  modred_link_pkg::lane_mask_t lane_start;
  modred_link_pkg::lane_mask_t lane_done;
  modred_link_pkg::lane_mask_t lane_release;

  // Per-lane result fields
  logic [`MODRED_MOD_W-1:0]    lane_result [`MODRED_NUM_LANES];
  logic                        lane_err [`MODRED_NUM_LANES];
  modred_link_pkg::tag_t       lane_tag [`MODRED_NUM_LANES];

  // ------------------------------------------------------------
  // Request side
  // ------------------------------------------------------------
  modred_dispatch u_dispatch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .lane_release_i (lane_release),
    .lane_start_o   (lane_start),
    .req_credit_o   (req_credit_o)
  );

  // Request fields are shared, start picks the lane
  for (genvar g = 0; g < `MODRED_NUM_LANES; g++) begin : g_lane
    modred_fold_lane u_lane (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .start_i   (lane_start[g]),
      .x_i       (req_x_i),
      .m_i       (req_m_i),
      .m_bl_i    (req_m_bl_i),
      .tag_i     (req_tag_i),
      .release_i (lane_release[g]),
      .done_o    (lane_done[g]),
      .result_o  (lane_result[g]),
      .err_o     (lane_err[g]),
      .tag_o     (lane_tag[g])
    );
  end

  // ------------------------------------------------------------
  // Response side
  // ------------------------------------------------------------
  modred_result_arb u_result_arb (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lane_done_i    (lane_done),
    .lane_result_i  (lane_result),
    .lane_err_i     (lane_err),
    .lane_tag_i     (lane_tag),
    .out_credit_i   (out_credit_i),
    .lane_release_o (lane_release),
    .resp_valid_o   (resp_valid_o),
    .resp_result_o  (resp_result_o),
    .resp_err_o     (resp_err_o),
    .resp_tag_o     (resp_tag_o)
  );

endmodule

/* dv/modred_assert.sv */
`timescale 1ns/1ps
`include "modred_settings.svh"

module modred_assert (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      req_valid_i,
  input logic [`MODRED_DATA_W-1:0] req_x_i,
  input logic [`MODRED_MOD_W-1:0]  req_m_i,
  input logic [5:0]                req_m_bl_i,
  input modred_link_pkg::tag_t     req_tag_i,
  input logic                      req_credit_o,
  input logic                      out_credit_i,
  input logic                      resp_valid_o,
  input logic [`MODRED_MOD_W-1:0]  resp_result_o,
  input logic                      resp_err_o,
  input modred_link_pkg::tag_t     resp_tag_o
);

  localparam int MW = `MODRED_MOD_W;
  localparam int DW = `MODRED_DATA_W;
  localparam int NT = 1 << `MODRED_TAG_W;

  // Failed checks, watched by the testbench
  int fail_cnt = 0;

  // Expected answer per tag, captured with the request
  logic [MW-1:0] exp_res [NT];
  logic          exp_err [NT];
  // Tags in flight
  logic [NT-1:0] pending;
  // Credit views of both channels
  int            resp_cred;
  int            host_cred;

  // Supported moduli from their definitions, length limits first
  function automatic logic special_mod(input logic [MW-1:0] m, input logic [5:0] bl);
    logic [MW:0] p;
    p = (MW+1)'(1) << bl;
    if ((bl < 6'd2) || (bl > 6'(MW))) begin
      return 1'b0;
    end
    return (m == MW'(3329)) || (m == MW'(8380417)) ||
           ({1'b0, m} == p - (MW+1)'(1)) || ({1'b0, m} == (p >> 1) + (MW+1)'(1));
  endfunction

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending   <= '0;
      resp_cred <= `MODRED_OUT_CREDITS;
      host_cred <= `MODRED_NUM_LANES;
    end else begin
      resp_cred <= resp_cred - int'(resp_valid_o) + int'(out_credit_i);
      host_cred <= host_cred - int'(req_valid_i) + int'(req_credit_o);
      // Set after clear, a freed tag may be reused at once
      if (resp_valid_o) begin
        pending[resp_tag_o] <= 1'b0;
      end
      if (req_valid_i) begin
        pending[req_tag_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      exp_err[req_tag_i] <= !special_mod(req_m_i, req_m_bl_i);
      exp_res[req_tag_i] <= special_mod(req_m_i, req_m_bl_i) ?
                            MW'(req_x_i % DW'(req_m_i)) : '0;
    end
  end

  // ------------------------------------------------------------
  // Response checks
  // ------------------------------------------------------------
  a_mod_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && pending[resp_tag_o] && !exp_err[resp_tag_o] |->
      !resp_err_o && (resp_result_o == exp_res[resp_tag_o]))
    else begin
      fail_cnt++;
      $error("FAILED at %0t: tag %0d gave %0h err %0b, expected %0h", $time,
             $sampled(resp_tag_o), $sampled(resp_result_o), $sampled(resp_err_o),
             exp_res[$sampled(resp_tag_o)]);
    end

  a_unsupported: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && pending[resp_tag_o] && exp_err[resp_tag_o] |->
      resp_err_o && (resp_result_o == '0))
    else begin
      fail_cnt++;
      $error("FAILED at %0t: tag %0d unsupported modulus not flagged, result %0h",
             $time, $sampled(resp_tag_o), $sampled(resp_result_o));
    end

  // Flow control on both channels
  a_resp_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> (resp_cred > 0))
    else begin
      fail_cnt++;
      $error("Response sent while the sink held no credit, at %0t", $time);
    end

  a_req_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_credit_o == resp_valid_o) && (host_cred <= `MODRED_NUM_LANES))
    else begin
      fail_cnt++;
      $error("Request credit pulse not matched to a response, at %0t", $time);
    end

  a_tag_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> pending[resp_tag_o])
    else begin
      fail_cnt++;
      $error("Response tag %0d has no outstanding request, at %0t",
             $sampled(resp_tag_o), $time);
    end

  // Quiet outputs right after reset
  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !resp_valid_o && !req_credit_o)
    else begin
      fail_cnt++;
      $error("Response or credit active in the first cycle after reset, at %0t", $time);
    end

endmodule

/* dv/modred_tb.sv */
`timescale 1ns/1ps
`include "modred_settings.svh"

module modred_tb;

  localparam int NUM_REQ    = 60;
  // 40 cycles per request plus drain margin
  localparam int MAX_CYCLES = NUM_REQ * 40 + 200;
  localparam int NUM_TAGS   = 1 << `MODRED_TAG_W;

  logic                         clk = 1'b0;
  logic                         rst_n;
  logic                         req_valid;
  logic [`MODRED_DATA_W-1:0]    req_x;
  logic [`MODRED_MOD_W-1:0]     req_m;
  logic [5:0]                   req_m_bl;
  modred_link_pkg::tag_t        req_tag;
  logic                         req_credit;
  logic                         out_credit;
  logic                         resp_valid;
  logic [`MODRED_MOD_W-1:0]     resp_result;
  logic                         resp_err;
  modred_link_pkg::tag_t        resp_tag;

  logic [63:0]                  rng_q;
  int                           cycle = 0;
  int                           host_credits;
  int                           sent;
  int                           pending_cnt;
  // Tags free for new requests
  modred_link_pkg::tag_t        free_tags [$];
  // Cycles at which the sink hands back a credit
  int                           credit_due [$];

  modred_top uut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_valid_i   (req_valid),
    .req_x_i       (req_x),
    .req_m_i       (req_m),
    .req_m_bl_i    (req_m_bl),
    .req_tag_i     (req_tag),
    .req_credit_o  (req_credit),
    .out_credit_i  (out_credit),
    .resp_valid_o  (resp_valid),
    .resp_result_o (resp_result),
    .resp_err_o    (resp_err),
    .resp_tag_o    (resp_tag)
  );

  bind modred_top modred_assert u_assert (.*);

  always #10 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  // xorshift64 step on the shared state
  function automatic logic [63:0] next_rand();
    rng_q = rng_q ^ (rng_q << 13);
    rng_q = rng_q ^ (rng_q >> 7);
    rng_q = rng_q ^ (rng_q << 17);
    return rng_q;
  endfunction

  // ------------------------------------------------------------
  // Watchdogs
  // ------------------------------------------------------------
  always @(posedge clk) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles, responses still missing", cycle));
    end
  end

  always @(uut.u_assert.fail_cnt) begin
    if (uut.u_assert.fail_cnt != 0) begin
      abort_run("An assertion check failed, see the error above");
    end
  end

  // ------------------------------------------------------------
  // Host and sink
  // ------------------------------------------------------------
  task automatic send_request();
    logic [63:0] r;
    logic [63:0] xr;
    logic [4:0]  k;
    logic [3:0]  sel;
    r   = next_rand();
    xr  = next_rand();
    // Fold width 2 to 31
    k   = 5'(2 + (r[15:8] % 30));
    sel = r[3:0];
    if (sel < 4'd5) begin
      req_m    = (`MODRED_MOD_W'(1) << k) - `MODRED_MOD_W'(1);
      req_m_bl = 6'(k);
    end else if (sel < 4'd10) begin
      req_m    = (`MODRED_MOD_W'(1) << k) + `MODRED_MOD_W'(1);
      req_m_bl = 6'(k) + 6'd1;
    end else if (sel < 4'd12) begin
      req_m    = `MODRED_MOD_W'(3329);
      req_m_bl = 6'd12;
    end else if (sel < 4'd14) begin
      req_m    = `MODRED_MOD_W'(8380417);
      req_m_bl = 6'd23;
    end else if (sel == 4'd14) begin
      // Generic odd value that is not special
      req_m    = (r[63:32] | 32'h8000_0005) & 32'hFFFF_FFFD;
      req_m_bl = 6'd32;
    end else begin
      // Known prime with an illegal length
      req_m    = `MODRED_MOD_W'(3329);
      req_m_bl = 6'd40;
    end
    // Occasional extremes of x
    case (r[6:4])
      3'd0:    req_x = '1;
      3'd1:    req_x = {56'd0, xr[7:0]};
      default: req_x = xr;
    endcase
    req_tag   = free_tags.pop_front();
    req_valid = 1'b1;
    host_credits--;
    sent++;
    pending_cnt++;
  endtask

  // At most one credit pulse per cycle
  task automatic return_credit();
    for (int i = 0; i < credit_due.size(); i++) begin
      if (credit_due[i] <= cycle) begin
        credit_due.delete(i);
        out_credit = 1'b1;
        break;
      end
    end
  endtask

  initial begin
    rng_q        = 64'd20554;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_x        = '0;
    req_m        = '0;
    req_m_bl     = '0;
    req_tag      = '0;
    out_credit   = 1'b0;
    host_credits = `MODRED_NUM_LANES;
    sent         = 0;
    pending_cnt  = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      free_tags.push_back(modred_link_pkg::tag_t'(t));
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    while ((sent < NUM_REQ) || (pending_cnt != 0)) begin
      @(negedge clk);
      req_valid  = 1'b0;
      out_credit = 1'b0;
      if (req_credit) begin
        host_credits++;
      end
      if (resp_valid) begin
        free_tags.push_back(resp_tag);
        pending_cnt--;
        credit_due.push_back(cycle + int'(next_rand() % 7));
      end
      return_credit();
      // Idle gaps between requests
      if ((sent < NUM_REQ) && (host_credits > 0) && (next_rand() % 4 != 0)) begin
        send_request();
      end
    end

    // Last response still has to pass the checks at the next edge
    @(negedge clk);
    if ((free_tags.size() != NUM_TAGS) || (host_credits != `MODRED_NUM_LANES)) begin
      abort_run("Tags or request credits left outstanding at the end of the run");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

/* tb.f */
+incdir+rtl
rtl/modred_arith_pkg.sv
rtl/modred_link_pkg.sv
rtl/modred_classifier.sv
rtl/modred_fold_lane.sv
rtl/modred_dispatch.sv
rtl/modred_result_arb.sv
rtl/modred_top.sv
dv/modred_assert.sv
dv/modred_tb.sv
